//--- build.f
hdl/phy_mdio_pkg.sv
hdl/phy_ext_write_sequencer.sv
hdl/mdc_clock_gen.sv
hdl/mdio_frame_shifter.sv
hdl/phy_mdio_init_top.sv
testbench/tb_clock_gen.sv
testbench/mdio_phy_model.sv
testbench/phy_mdio_init_tb.sv

//--- hdl/mdc_clock_gen.sv
// MDC generator, toggles every mdc_prescale+1 clocks while a frame runs and flags each falling edge
`timescale 1ns/100ps

module mdc_clock_gen #(
    parameter int mdc_prescale = 3
) (
    input  logic clk_125mhz,
    input  logic rst_125mhz,
    input  logic mdc_run,
    output logic mdc,
    output logic bit_strobe
);

    localparam int cnt_w = (mdc_prescale > 0) ? $clog2(mdc_prescale + 1) : 1;

    logic [cnt_w-1:0] phase_cnt;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            mdc <= 1'b0;
            phase_cnt <= cnt_w'(mdc_prescale);
            bit_strobe <= 1'b0;
        end else begin
            bit_strobe <= 1'b0;
            if (!mdc_run) begin
                // park low, next frame starts with a full low phase
                mdc <= 1'b0;
                phase_cnt <= cnt_w'(mdc_prescale);
            end else if (phase_cnt == '0) begin
                mdc <= ~mdc;
                phase_cnt <= cnt_w'(mdc_prescale);
                bit_strobe <= mdc;
            end else begin
                phase_cnt <= phase_cnt - 1'b1;
            end
        end
    end

endmodule

//--- hdl/mdio_frame_shifter.sv
// MDIO write-frame shifter, takes one command and drives preamble plus frame msb first on MDIO
`timescale 1ns/100ps

module mdio_frame_shifter (
    input  logic                    clk_125mhz,
    input  logic                    rst_125mhz,
    input  phy_mdio_pkg::mdio_cmd_t cmd,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  logic                    bit_strobe,
    output logic                    mdc_run,
    output logic                    mdio_o,
    output logic                    mdio_t
);
    import phy_mdio_pkg::*;

    localparam int frame_bits = mdio_preamble_bits + $bits(mdio_cmd_t);
    localparam int count_w = $clog2(frame_bits);

    logic                  busy;
    logic                  cmd_accept;
    logic [frame_bits-1:0] shift_reg;
    logic [count_w-1:0]    bit_cnt;

    // one frame in flight, ready only while idle
    assign cmd_ready = ~busy;
    assign cmd_accept = cmd_valid && cmd_ready;

    assign mdc_run = busy;
    assign mdio_t = ~busy;

    // current bit sits at the top of the shift register
    assign mdio_o = shift_reg[frame_bits-1];

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            busy <= 1'b0;
            bit_cnt <= '0;
            shift_reg <= '1;
        end else if (cmd_accept) begin
            busy <= 1'b1;
            bit_cnt <= count_w'(frame_bits - 1);
            shift_reg <= {{mdio_preamble_bits{1'b1}}, cmd.word};
        end else if (busy && bit_strobe) begin
            // next bit goes out just after MDC falls
            shift_reg <= {shift_reg[frame_bits-2:0], 1'b1};
            if (bit_cnt == '0) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

endmodule

//--- hdl/phy_ext_write_sequencer.sv
// waits out the start-up delay, then issues the extended PHY writes as REGCR/ADDAR clause-22 commands
`timescale 1ns/100ps

module phy_ext_write_sequencer #(
    parameter int         init_delay_cycles = 1048575,
    parameter logic [4:0] phy_addr = 5'd3
) (
    input  logic                    clk_125mhz,
    input  logic                    rst_125mhz,
    output phy_mdio_pkg::mdio_cmd_t cmd,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    output logic                    init_done
);
    import phy_mdio_pkg::*;

    localparam int delay_w = (init_delay_cycles > 0) ? $clog2(init_delay_cycles + 1) : 1;
    localparam int index_w = (ext_write_count > 1) ? $clog2(ext_write_count) : 1;

    logic [delay_w-1:0] delay_cnt;
    logic               delay_last;
    logic               running;
    logic [index_w-1:0] entry_idx;
    logic [1:0]         step;
    logic               drain_pending;
    logic               cmd_fire;
    logic               last_cmd;
    ext_write_t         cur_entry;

    assign delay_last = (delay_cnt <= delay_w'(1));
    assign cmd_fire = cmd_valid && cmd_ready;
    assign last_cmd = (entry_idx == index_w'(ext_write_count - 1)) && (step == 2'd3);

    // command word follows index and step, so it holds while valid waits
    always_comb begin
        cur_entry = ext_write_table[entry_idx];
        cmd.fields.st = mdio_st_clause22;
        cmd.fields.op = mdio_op_write;
        cmd.fields.phy_addr = phy_addr;
        cmd.fields.ta = mdio_ta_write;
        case (step)
            2'd0: begin
                // select address mode
                cmd.fields.reg_addr = regcr_addr;
                cmd.fields.data = regcr_addr_mode;
            end
            2'd1: begin
                cmd.fields.reg_addr = addar_addr;
                cmd.fields.data = cur_entry.ext_addr;
            end
            2'd2: begin
                // switch to data mode, no post increment
                cmd.fields.reg_addr = regcr_addr;
                cmd.fields.data = regcr_data_mode;
            end
            default: begin
                cmd.fields.reg_addr = addar_addr;
                cmd.fields.data = cur_entry.value;
            end
        endcase
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            delay_cnt <= delay_w'(init_delay_cycles);
            running <= 1'b0;
            entry_idx <= '0;
            step <= '0;
            cmd_valid <= 1'b0;
            drain_pending <= 1'b0;
            init_done <= 1'b0;
        end else begin
            if (delay_cnt != '0) begin
                delay_cnt <= delay_cnt - 1'b1;
            end

            if (!running && delay_last) begin
                // first command goes out as the delay runs out
                running <= 1'b1;
                cmd_valid <= 1'b1;
            end else if (cmd_fire) begin
                if (last_cmd) begin
                    cmd_valid <= 1'b0;
                    drain_pending <= 1'b1;
                end else begin
                    step <= step + 2'd1;
                    if (step == 2'd3) begin
                        entry_idx <= entry_idx + 1'b1;
                    end
                end
            end

            // done once the shifter is idle again after the last frame
            if (drain_pending && cmd_ready) begin
                drain_pending <= 1'b0;
                init_done <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/phy_mdio_init_top.sv
// top of the PHY start-up configuration, sequencer feeding the MDIO shifter and MDC generator
`timescale 1ns/100ps

module phy_mdio_init_top #(
    parameter logic [4:0] phy_addr = 5'd3,
    parameter int         mdc_prescale = 3,
    parameter int         init_delay_cycles = 1048575
) (
    input  logic clk_125mhz,
    input  logic rst_125mhz,
    output logic phy_mdc,
    output logic phy_mdio_o,
    output logic phy_mdio_t,
    output logic init_done
);
    import phy_mdio_pkg::*;

    mdio_cmd_t cmd;
    logic      cmd_valid;
    logic      cmd_ready;
    logic      mdc_run;
    logic      bit_strobe;

    phy_ext_write_sequencer #(
        .init_delay_cycles(init_delay_cycles),
        .phy_addr(phy_addr)
    ) sequencer_inst (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .init_done(init_done)
    );

    mdio_frame_shifter shifter_inst (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .bit_strobe(bit_strobe),
        .mdc_run(mdc_run),
        .mdio_o(phy_mdio_o),
        .mdio_t(phy_mdio_t)
    );

    mdc_clock_gen #(
        .mdc_prescale(mdc_prescale)
    ) mdc_gen_inst (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .mdc_run(mdc_run),
        .mdc(phy_mdc),
        .bit_strobe(bit_strobe)
    );

endmodule

//--- hdl/phy_mdio_pkg.sv
// shared MDIO frame types, clause-22 field constants and the PHY extended-register write table

package phy_mdio_pkg;

    // one clause-22 management frame, msb first on the wire
    typedef struct packed {
        logic [1:0]  st;
        logic [1:0]  op;
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        logic [1:0]  ta;
        logic [15:0] data;
    } mdio_cmd_fields_t;

    // fields for the sequencer, flat word for the shifter
    typedef union packed {
        mdio_cmd_fields_t fields;
        logic [31:0]      word;
    } mdio_cmd_t;

    // one write to the extended register space
    typedef struct packed {
        logic [15:0] ext_addr;
        logic [15:0] value;
    } ext_write_t;

    localparam logic [1:0] mdio_st_clause22 = 2'b01;
    localparam logic [1:0] mdio_op_write = 2'b01;
    localparam logic [1:0] mdio_ta_write = 2'b10;
    localparam int mdio_preamble_bits = 32;

    // indirect access through REGCR/ADDAR, device address 0x1F
    localparam logic [4:0] regcr_addr = 5'h0D;
    localparam logic [4:0] addar_addr = 5'h0E;
    localparam logic [15:0] regcr_addr_mode = 16'h001F;
    localparam logic [15:0] regcr_data_mode = 16'h401F;

    localparam int ext_write_count = 3;

    localparam ext_write_t ext_write_table [ext_write_count] = '{
        // CFG4, SGMII autonegotiation timer
        '{ext_addr: 16'h0031, value: 16'h0070},
        // SGMIICTL1, SGMII clock output
        '{ext_addr: 16'h00D3, value: 16'h4000},
        // 10M_SGMII_CFG, 10 Mbps operation
        '{ext_addr: 16'h016F, value: 16'h0015}
    };

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module phy_mdio_init_tb -f build.f \
    && ./obj_dir/Vphy_mdio_init_tb | tee /dev/stderr | grep -F "RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- testbench/mdio_phy_model.sv
// PHY-side MDIO monitor for the testbench, captures write frames and measures the MDC phases
`timescale 1ns/100ps

module mdio_phy_model (
    input  logic        clk_125mhz,
    input  logic        mdc,
    input  logic        mdio_o,
    input  logic        mdio_t,
    output logic        frame_valid,
    output logic [63:0] frame_data,
    output int          frame_len,
    output logic        phase_valid,
    output int          phase_len,
    output logic        mdio_moved_high,
    output logic        idle_mdc_high
);

    logic        prev_mdc = 1'b0;
    logic        prev_mdio_o = 1'b1;
    logic        prev_mdio_t = 1'b1;
    logic        phase_armed = 1'b0;
    int          phase_cnt = 0;
    int          bit_cnt = 0;
    logic [63:0] shift = '0;

    initial begin
        frame_valid = 1'b0;
        frame_data = '0;
        frame_len = 0;
        phase_valid = 1'b0;
        phase_len = 0;
        mdio_moved_high = 1'b0;
        idle_mdc_high = 1'b0;
    end

    // bus signals settle after the rising clock edge, so look at them on the falling one
    always @(negedge clk_125mhz) begin
        frame_valid <= 1'b0;
        phase_valid <= 1'b0;
        mdio_moved_high <= mdc && (mdio_o !== prev_mdio_o);
        idle_mdc_high <= mdio_t && mdc;

        // an MDC edge closes the previous phase, a reset cut is not reported
        if (mdc != prev_mdc) begin
            phase_valid <= phase_armed && !mdio_t;
            phase_len <= phase_cnt;
            phase_cnt <= 1;
            phase_armed <= 1'b1;
        end else begin
            phase_cnt <= phase_cnt + 1;
        end
        if (mdio_t) begin
            phase_armed <= 1'b0;
        end

        // PHY samples MDIO on the rising MDC edge
        if (!mdio_t && mdc && !prev_mdc) begin
            shift <= {shift[62:0], mdio_o};
            bit_cnt <= bit_cnt + 1;
        end
        if (mdio_t && !prev_mdio_t) begin
            frame_valid <= 1'b1;
            frame_data <= shift;
            frame_len <= bit_cnt;
            bit_cnt <= 0;
        end

        prev_mdc <= mdc;
        prev_mdio_o <= mdio_o;
        prev_mdio_t <= mdio_t;
    end

endmodule

//--- testbench/phy_mdio_init_tb.sv
// testbench top for the PHY MDIO start-up configuration that run_sim.sh builds and runs
`timescale 1ns/100ps

module phy_mdio_init_tb;
    import phy_mdio_pkg::*;

    localparam logic [4:0] phy_addr = 5'd3;
    localparam int mdc_prescale = 3;
    localparam int init_delay_cycles = 100;
    localparam int frame_count = 4 * ext_write_count;
    localparam int restart_after_frames = 5;
    localparam int quiet_cycles = 2000;
    // two passes of the whole sequence plus margin
    localparam int watchdog_cycles =
        init_delay_cycles + 2 * frame_count * 64 * 2 * (mdc_prescale + 1) + 500;

    logic        clk_125mhz;
    logic        por_rst;
    logic        restart_rst;
    logic        rst_125mhz;
    logic        phy_mdc;
    logic        phy_mdio_o;
    logic        phy_mdio_t;
    logic        init_done;
    logic        frame_valid;
    logic [63:0] frame_data;
    int          frame_len;
    logic        phase_valid;
    int          phase_len;
    logic        mdio_moved_high;
    logic        idle_mdc_high;

    assign rst_125mhz = por_rst || restart_rst;

    tb_clock_gen clock_gen_inst (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(por_rst)
    );

    phy_mdio_init_top #(
        .phy_addr(phy_addr),
        .mdc_prescale(mdc_prescale),
        .init_delay_cycles(init_delay_cycles)
    ) DUT (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .phy_mdc(phy_mdc),
        .phy_mdio_o(phy_mdio_o),
        .phy_mdio_t(phy_mdio_t),
        .init_done(init_done)
    );

    mdio_phy_model phy_model_inst (
        .clk_125mhz(clk_125mhz),
        .mdc(phy_mdc),
        .mdio_o(phy_mdio_o),
        .mdio_t(phy_mdio_t),
        .frame_valid(frame_valid),
        .frame_data(frame_data),
        .frame_len(frame_len),
        .phase_valid(phase_valid),
        .phase_len(phase_len),
        .mdio_moved_high(mdio_moved_high),
        .idle_mdc_high(idle_mdc_high)
    );

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s: expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        assert (cond) else begin
            $display("ERROR: %s", what);
            abort_run();
        end
    endtask

    // bus released and init_done low through reset and the start-up delay
    task automatic check_startup_idle();
        int i;
        @(negedge clk_125mhz);
        for (i = 0; rst_125mhz || i < init_delay_cycles; i += rst_125mhz ? 0 : 1) begin
            check_value("startup_mdc", 32'd0, 32'(phy_mdc));
            check_value("startup_mdio_t", 32'd1, 32'(phy_mdio_t));
            check_value("startup_init_done", 32'd0, 32'(init_done));
            @(negedge clk_125mhz);
        end
        i = 0;
        while (phy_mdio_t && i < 4) begin
            @(negedge clk_125mhz);
            i++;
        end
        check_true("first frame did not start right after the start-up delay", !phy_mdio_t);
    endtask

    // next captured frame against the REGCR/ADDAR expansion of the table
    task automatic receive_frame(input int idx);
        mdio_cmd_t   got;
        ext_write_t  entry;
        logic [4:0]  exp_reg;
        logic [15:0] exp_data;
        entry = ext_write_table[idx / 4];
        exp_reg = (idx % 2 == 0) ? regcr_addr : addar_addr;
        case (idx % 4)
            0: exp_data = regcr_addr_mode;
            1: exp_data = entry.ext_addr;
            2: exp_data = regcr_data_mode;
            default: exp_data = entry.value;
        endcase
        do begin
            @(posedge clk_125mhz);
        end while (!frame_valid);
        got.word = frame_data[31:0];
        check_value($sformatf("frame%0d_length", idx), 32'd64, frame_len);
        check_value($sformatf("frame%0d_preamble", idx), 32'hffff_ffff, frame_data[63:32]);
        check_value($sformatf("frame%0d_st", idx), 32'(mdio_st_clause22), 32'(got.fields.st));
        check_value($sformatf("frame%0d_op", idx), 32'(mdio_op_write), 32'(got.fields.op));
        check_value($sformatf("frame%0d_phy_addr", idx), 32'(phy_addr),
                    32'(got.fields.phy_addr));
        check_value($sformatf("frame%0d_ta", idx), 32'(mdio_ta_write), 32'(got.fields.ta));
        check_value($sformatf("frame%0d_reg_addr", idx), 32'(exp_reg),
                    32'(got.fields.reg_addr));
        check_value($sformatf("frame%0d_data", idx), 32'(exp_data), 32'(got.fields.data));
        @(negedge clk_125mhz);
        check_value($sformatf("frame%0d_init_done", idx), 32'(idx == frame_count - 1),
                    32'(init_done));
    endtask

    always @(posedge clk_125mhz) begin
        if (phase_valid) begin
            check_value("mdc_phase_length", mdc_prescale + 1, phase_len);
        end
        check_true("phy_mdio_o changed while phy_mdc was high", !mdio_moved_high);
        check_true("phy_mdc was high while the bus was released", !idle_mdc_high);
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_125mhz);
        $display("ERROR: watchdog expired after %0d cycles", watchdog_cycles);
        abort_run();
    end

    initial begin
        int i;
        restart_rst = 1'b0;
        check_startup_idle();
        for (i = 0; i < restart_after_frames; i++) begin
            receive_frame(i);
        end

        // reset during an MDC high phase in the middle of the following frame
        repeat (200) @(negedge clk_125mhz);
        while (!phy_mdc) begin
            @(negedge clk_125mhz);
        end
        check_value("restart_mid_frame_mdio_t", 32'd0, 32'(phy_mdio_t));
        @(posedge clk_125mhz);
        #1 restart_rst = 1'b1;
        @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        check_value("restart_mdio_t", 32'd1, 32'(phy_mdio_t));
        check_value("restart_mdc", 32'd0, 32'(phy_mdc));
        repeat (4) @(posedge clk_125mhz);
        #1 restart_rst = 1'b0;

        check_startup_idle();
        for (i = 0; i < frame_count; i++) begin
            receive_frame(i);
        end
        for (i = 0; i < quiet_cycles; i++) begin
            @(negedge clk_125mhz);
            check_value("quiet_mdio_t", 32'd1, 32'(phy_mdio_t));
            check_value("quiet_init_done", 32'd1, 32'(init_done));
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
// testbench clock and power-on reset, 8 ns clk_125mhz with reset held for the first cycles
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int reset_cycles = 5
) (
    output logic clk_125mhz,
    output logic rst_125mhz
);

    initial begin
        clk_125mhz = 1'b0;
        forever begin
            #4 clk_125mhz = ~clk_125mhz;
        end
    end

    // released a little after a rising edge
    initial begin
        rst_125mhz = 1'b1;
        repeat (reset_cycles) @(posedge clk_125mhz);
        #1 rst_125mhz = 1'b0;
    end

endmodule
